// File: include/cube_config.svh
`ifndef CUBE_CONFIG_SVH
`define CUBE_CONFIG_SVH

// Serial receiver, system clocks per bit
`define CUBE_CLKS_PER_BIT 8

// Servo PWM frame and high time per duty code unit
`define CUBE_SERVO_FRAME_CLKS 200
`define CUBE_SERVO_UNIT_CLKS 20

// Full frames a new position is held before the step completes
`define CUBE_SETTLE_FRAMES 2

// One directional and one gripper servo per row
`define CUBE_NUM_SERVOS 4

`endif

// File: logic/cube_pkg.sv
package cube_pkg;

    // Row moves, encoded as the index of the servo pair that turns the row
    typedef enum logic [1:0] {
        cmd_left   = 2'd0,
        cmd_top    = 2'd1,
        cmd_bottom = 2'd2,
        cmd_right  = 2'd3
    } cube_cmd_e;

    // Duty codes in units of the servo pulse step
    typedef enum logic [2:0] {
        pos_rest        = 3'd1,  // directional at 0 degrees, gripper open
        pos_grip_closed = 3'd2,
        pos_turned      = 3'd3   // directional at 90 degrees
    } servo_pos_e;

    typedef enum logic {
        grp_dir  = 1'b0,
        grp_grip = 1'b1
    } servo_group_e;

    // One servo move on the step link
    typedef struct packed {
        servo_group_e group;
        logic [1:0]   index;
        servo_pos_e   pos;
    } servo_step_t;

endpackage

// File: logic/cube_solver_top.sv
`timescale 1ns/1ps
`include "cube_config.svh"

module cube_solver_top (
    input  logic                        i_sys_clk,
    input  logic                        i_arst_n,
    input  logic                        i_rx_serial,
    output logic [`CUBE_NUM_SERVOS-1:0] o_servo_dir,
    output logic [`CUBE_NUM_SERVOS-1:0] o_servo_grip,
    output logic                        o_busy
);

    import cube_pkg::*;

    logic [7:0]  rx_byte;
    logic        rx_byte_valid;
    logic        cmd_req;
    cube_cmd_e   cmd;
    logic        cmd_ack;
    logic        step_req;
    servo_step_t step;
    logic        step_ack;

    //////////////////////////////////////////////////
    // Serial in and command decode
    //////////////////////////////////////////////////

    uart_rx u_uart_rx (
        .i_sys_clk    (i_sys_clk),
        .i_arst_n     (i_arst_n),
        .i_rx_serial  (i_rx_serial),
        .o_byte       (rx_byte),
        .o_byte_valid (rx_byte_valid)
    );

    move_decoder u_move_decoder (
        .i_sys_clk    (i_sys_clk),
        .i_arst_n     (i_arst_n),
        .i_byte       (rx_byte),
        .i_byte_valid (rx_byte_valid),
        .o_cmd_req    (cmd_req),
        .o_cmd        (cmd),
        .i_cmd_ack    (cmd_ack)
    );

    //////////////////////////////////////////////////
    // Move execution and servo outputs
    //////////////////////////////////////////////////

    move_sequencer u_move_sequencer (
        .i_sys_clk  (i_sys_clk),
        .i_arst_n   (i_arst_n),
        .i_cmd_req  (cmd_req),
        .i_cmd      (cmd),
        .o_cmd_ack  (cmd_ack),
        .o_step_req (step_req),
        .o_step     (step),
        .i_step_ack (step_ack),
        .o_busy     (o_busy)
    );

    servo_pwm_bank u_servo_pwm_bank (
        .i_sys_clk    (i_sys_clk),
        .i_arst_n     (i_arst_n),
        .i_step_req   (step_req),
        .i_step       (step),
        .o_step_ack   (step_ack),
        .o_servo_dir  (o_servo_dir),
        .o_servo_grip (o_servo_grip)
    );

endmodule

// File: logic/move_decoder.sv
`timescale 1ns/1ps

module move_decoder (
    input  logic                i_sys_clk,
    input  logic                i_arst_n,
    input  logic [7:0]          i_byte,
    input  logic                i_byte_valid,
    output logic                o_cmd_req,
    output cube_pkg::cube_cmd_e o_cmd,
    input  logic                i_cmd_ack
);

    import cube_pkg::*;

    logic      is_cmd;
    cube_cmd_e byte_cmd;
    logic      launch;

    // Command characters
    always_comb begin
        is_cmd   = 1'b1;
        byte_cmd = cmd_left;
        case (i_byte)
            "L":     byte_cmd = cmd_left;
            "T":     byte_cmd = cmd_top;
            "B":     byte_cmd = cmd_bottom;
            "R":     byte_cmd = cmd_right;
            default: is_cmd = 1'b0;
        endcase
    end

    // Only when the link is fully idle
    assign launch = i_byte_valid && is_cmd && !o_cmd_req && !i_cmd_ack;

    always_ff @(posedge i_sys_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_cmd_req <= 1'b0;
        end else if (launch) begin
            o_cmd_req <= 1'b1;
        end else if (o_cmd_req && i_cmd_ack) begin
            o_cmd_req <= 1'b0;
        end
    end

    always_ff @(posedge i_sys_clk) begin
        if (launch) begin
            o_cmd <= byte_cmd;
        end
    end

endmodule

// File: logic/move_sequencer.sv
`timescale 1ns/1ps

module move_sequencer (
    input  logic                  i_sys_clk,
    input  logic                  i_arst_n,
    input  logic                  i_cmd_req,
    input  cube_pkg::cube_cmd_e   i_cmd,
    output logic                  o_cmd_ack,
    output logic                  o_step_req,
    output cube_pkg::servo_step_t o_step,
    input  logic                  i_step_ack,
    output logic                  o_busy
);

    import cube_pkg::*;

    typedef enum logic [1:0] {st_idle, st_gap, st_req, st_release} seq_state_e;

    seq_state_e state;
    logic [1:0] step_cnt;
    logic [1:0] row_idx;
    logic       take_cmd;

    // A request during a move is acknowledged and thrown away
    assign take_cmd = i_cmd_req && !o_cmd_ack && (state == st_idle);

    //////////////////////////////////////////////////
    // Command link
    //////////////////////////////////////////////////

    always_ff @(posedge i_sys_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_cmd_ack <= 1'b0;
        end else if (i_cmd_req && !o_cmd_ack) begin
            o_cmd_ack <= 1'b1;
        end else if (!i_cmd_req && o_cmd_ack) begin
            o_cmd_ack <= 1'b0;
        end
    end

    // Command encoding is the servo index
    always_ff @(posedge i_sys_clk) begin
        if (take_cmd) begin
            row_idx <= i_cmd;
        end
    end

    //////////////////////////////////////////////////
    // Step link
    //////////////////////////////////////////////////

    always_ff @(posedge i_sys_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state      <= st_idle;
            step_cnt   <= '0;
            o_step_req <= 1'b0;
            o_busy     <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (take_cmd) begin
                        step_cnt <= '0;
                        state    <= st_gap;
                    end
                end
                st_gap: begin
                    o_step_req <= 1'b1;
                    o_busy     <= 1'b1;
                    state      <= st_req;
                end
                st_req: begin
                    if (i_step_ack) begin
                        o_step_req <= 1'b0;
                        state      <= st_release;
                    end
                end
                st_release: begin
                    if (!i_step_ack) begin
                        if (step_cnt == 2'd3) begin
                            o_busy <= 1'b0;
                            state  <= st_idle;
                        end else begin
                            step_cnt <= step_cnt + 1'b1;
                            state    <= st_gap;
                        end
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // Grip, turn, release, return
    always_comb begin
        o_step.index = row_idx;
        case (step_cnt)
            2'd0: begin
                o_step.group = grp_grip;
                o_step.pos   = pos_grip_closed;
            end
            2'd1: begin
                o_step.group = grp_dir;
                o_step.pos   = pos_turned;
            end
            2'd2: begin
                o_step.group = grp_grip;
                o_step.pos   = pos_rest;
            end
            default: begin
                o_step.group = grp_dir;
                o_step.pos   = pos_rest;
            end
        endcase
    end

endmodule

// File: logic/servo_pwm_bank.sv
`timescale 1ns/1ps
`include "cube_config.svh"

module servo_pwm_bank (
    input  logic                        i_sys_clk,
    input  logic                        i_arst_n,
    input  logic                        i_step_req,
    input  cube_pkg::servo_step_t       i_step,
    output logic                        o_step_ack,
    output logic [`CUBE_NUM_SERVOS-1:0] o_servo_dir,
    output logic [`CUBE_NUM_SERVOS-1:0] o_servo_grip
);

    import cube_pkg::*;

    localparam int frame_w  = $clog2(`CUBE_SERVO_FRAME_CLKS);
    localparam int settle_w = $clog2(`CUBE_SETTLE_FRAMES + 1);
    localparam logic [frame_w-1:0]  frame_last  = frame_w'(`CUBE_SERVO_FRAME_CLKS - 1);
    localparam logic [settle_w-1:0] settle_last = settle_w'(`CUBE_SETTLE_FRAMES - 1);

    logic [frame_w-1:0]  frame_cnt;
    logic                frame_end;
    logic                req_d;
    logic                pend_valid;
    servo_step_t         pend_step;
    logic                settling;
    logic [settle_w-1:0] settle_cnt;
    servo_pos_e          dir_pos  [`CUBE_NUM_SERVOS];
    servo_pos_e          grip_pos [`CUBE_NUM_SERVOS];

    function automatic logic [frame_w-1:0] high_clks(input servo_pos_e pos);
        return frame_w'(int'(pos) * `CUBE_SERVO_UNIT_CLKS);
    endfunction

    //////////////////////////////////////////////////
    // Frame timing
    //////////////////////////////////////////////////

    assign frame_end = (frame_cnt == frame_last);

    always_ff @(posedge i_sys_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            frame_cnt <= '0;
        end else begin
            frame_cnt <= frame_end ? '0 : frame_cnt + 1'b1;
        end
    end

    //////////////////////////////////////////////////
    // Step handling
    //////////////////////////////////////////////////

    always_ff @(posedge i_sys_clk) begin
        if (i_step_req && !req_d) begin
            pend_step <= i_step;
        end
    end

    always_ff @(posedge i_sys_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            req_d      <= 1'b0;
            pend_valid <= 1'b0;
            settling   <= 1'b0;
            settle_cnt <= '0;
            o_step_ack <= 1'b0;
            for (int n = 0; n < `CUBE_NUM_SERVOS; n++) begin
                dir_pos[n]  <= pos_rest;
                grip_pos[n] <= pos_rest;
            end
        end else begin
            req_d <= i_step_req;
            if (i_step_req && !req_d) begin
                pend_valid <= 1'b1;
            end
            if (frame_end) begin
                // New target takes effect with the next frame
                if (pend_valid) begin
                    if (pend_step.group == grp_grip) begin
                        grip_pos[pend_step.index] <= pend_step.pos;
                    end else begin
                        dir_pos[pend_step.index] <= pend_step.pos;
                    end
                    pend_valid <= 1'b0;
                    settling   <= 1'b1;
                    settle_cnt <= '0;
                end else if (settling) begin
                    if (settle_cnt == settle_last) begin
                        settling   <= 1'b0;
                        o_step_ack <= 1'b1;
                    end else begin
                        settle_cnt <= settle_cnt + 1'b1;
                    end
                end
            end
            if (o_step_ack && !i_step_req) begin
                o_step_ack <= 1'b0;
            end
        end
    end

    // Pulses high at the start of each frame
    always_ff @(posedge i_sys_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_servo_dir  <= '0;
            o_servo_grip <= '0;
        end else begin
            for (int n = 0; n < `CUBE_NUM_SERVOS; n++) begin
                o_servo_dir[n]  <= (frame_cnt < high_clks(dir_pos[n]));
                o_servo_grip[n] <= (frame_cnt < high_clks(grip_pos[n]));
            end
        end
    end

endmodule

// File: logic/uart_rx.sv
`timescale 1ns/1ps
`include "cube_config.svh"

module uart_rx (
    input  logic       i_sys_clk,
    input  logic       i_arst_n,
    input  logic       i_rx_serial,
    output logic [7:0] o_byte,
    output logic       o_byte_valid
);

    localparam int cnt_w = $clog2(`CUBE_CLKS_PER_BIT);
    localparam logic [cnt_w-1:0] bit_last  = cnt_w'(`CUBE_CLKS_PER_BIT - 1);
    localparam logic [cnt_w-1:0] half_last = cnt_w'(`CUBE_CLKS_PER_BIT / 2 - 1);

    typedef enum logic [1:0] {st_idle, st_start, st_data, st_stop} rx_state_e;

    logic [1:0]       rx_sync;
    logic             rx_prev;
    rx_state_e        state;
    logic [cnt_w-1:0] clk_cnt;
    logic [2:0]       bit_idx;
    logic [7:0]       shift;

    // Two-flop synchronizer, plus one flop for start edge detection
    always_ff @(posedge i_sys_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            rx_sync <= 2'b11;
            rx_prev <= 1'b1;
        end else begin
            rx_sync <= {rx_sync[0], i_rx_serial};
            rx_prev <= rx_sync[1];
        end
    end

    always_ff @(posedge i_sys_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state        <= st_idle;
            clk_cnt      <= '0;
            bit_idx      <= '0;
            o_byte_valid <= 1'b0;
        end else begin
            o_byte_valid <= 1'b0;
            case (state)
                st_idle: begin
                    clk_cnt <= '0;
                    bit_idx <= '0;
                    // A held low line after a bad frame is not a new start
                    if (rx_prev && !rx_sync[1]) begin
                        state <= st_start;
                    end
                end
                st_start: begin
                    if (clk_cnt == half_last) begin
                        clk_cnt <= '0;
                        state   <= rx_sync[1] ? st_idle : st_data;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                st_data: begin
                    if (clk_cnt == bit_last) begin
                        clk_cnt <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= st_stop;
                        end
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                st_stop: begin
                    if (clk_cnt == bit_last) begin
                        // Framing error leaves the strobe low
                        o_byte_valid <= rx_sync[1];
                        state        <= st_idle;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // LSB first, sampled mid bit
    always_ff @(posedge i_sys_clk) begin
        if (state == st_data && clk_cnt == bit_last) begin
            shift <= {rx_sync[1], shift[7:1]};
        end
    end

    assign o_byte = shift;

endmodule

// File: sim/tb_cube_solver.sv
`timescale 1ns/1ps
`include "cube_config.svh"

module tb_cube_solver;

    localparam int clks = `CUBE_CLKS_PER_BIT;
    localparam int frame = `CUBE_SERVO_FRAME_CLKS;
    // Four steps of up to three frames each, eight moves, serial time, twofold margin
    localparam int move_cycles = 4 * 3 * frame;
    localparam int timeout_cycles = 2 * (8 * move_cycles + 800);

    logic       sys_clk;
    logic       arst_n;
    logic       rx_serial;
    logic [3:0] servo_dir;
    logic [3:0] servo_grip;
    logic       busy;
    logic [7:0] servo_bits;

    integer     seed;
    int         err_cnt;
    int         cycle_cnt;
    int         hi_cnt [8];
    logic [2:0] obs_code [8];
    logic [5:0] ev_log [$];
    logic       busy_seen;

    cube_solver_top dut (
        .i_sys_clk    (sys_clk),
        .i_arst_n     (arst_n),
        .i_rx_serial  (rx_serial),
        .o_servo_dir  (servo_dir),
        .o_servo_grip (servo_grip),
        .o_busy       (busy)
    );

    assign servo_bits = {servo_grip, servo_dir};

    always #5 sys_clk = ~sys_clk;

    always @(posedge sys_clk) begin
        cycle_cnt++;
        if (cycle_cnt >= timeout_cycles) begin
            $display("Timeout: run did not finish within %0d cycles", timeout_cycles);
            $display("Testbench failed");
            $finish;
        end
    end

    //////////////////////////////////////////////////
    // Pulse monitors, one event per change of code
    //////////////////////////////////////////////////

    always @(negedge sys_clk) begin : monitor_servos
        logic [2:0] code;
        for (int s = 0; s < 8; s++) begin
            if (servo_bits[s]) begin
                hi_cnt[s]++;
            end else if (hi_cnt[s] != 0) begin
                code = 3'(hi_cnt[s] / `CUBE_SERVO_UNIT_CLKS);
                if (obs_code[s] != 0 && code != obs_code[s]) begin
                    ev_log.push_back({s >= 4, 2'(s), code});
                end
                obs_code[s] = code;
                hi_cnt[s] = 0;
            end
        end
        if (busy) begin
            busy_seen = 1'b1;
        end
    end

    // Events are {gripper, index, code}, first event in the top bits, empty list is zero
    function automatic logic [23:0] expected_events(input logic [7:0] b);
        logic [1:0] n;
        logic       is_move;
        is_move = 1'b1;
        n = 2'd0;
        case (b)
            "L":     n = 2'd0;
            "T":     n = 2'd1;
            "B":     n = 2'd2;
            "R":     n = 2'd3;
            default: is_move = 1'b0;
        endcase
        if (!is_move) begin
            return '0;
        end
        return {1'b1, n, 3'd2, 1'b0, n, 3'd3, 1'b1, n, 3'd1, 1'b0, n, 3'd1};
    endfunction

    function automatic logic all_observed();
        for (int s = 0; s < 8; s++) begin
            if (obs_code[s] == 0) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    task automatic send_bit(input logic v);
        rx_serial = v;
        repeat (clks) @(negedge sys_clk);
    endtask

    // Random idle gap, then 8N1 frame
    task automatic send_frame(input logic [7:0] b, input logic stop_bit);
        int gap;
        gap = 1 + ($unsigned($random(seed)) % 8);
        rx_serial = 1'b1;
        repeat (gap * clks) @(negedge sys_clk);
        send_bit(1'b0);
        for (int i = 0; i < 8; i++) begin
            send_bit(b[i]);
        end
        send_bit(stop_bit);
        rx_serial = 1'b1;
    endtask

    task automatic wait_busy(input logic level, input int limit, output logic ok);
        int n;
        n = 0;
        while (busy !== level && n < limit) begin
            @(negedge sys_clk);
            n++;
        end
        ok = (busy === level);
    endtask

    task automatic compare_events(input string name, input logic [23:0] exp);
        int         n_exp;
        logic [5:0] e;
        n_exp = 0;
        for (int i = 0; i < 4; i++) begin
            if (exp[23-6*i -: 6] != 0) begin
                n_exp++;
            end
        end
        if (ev_log.size() != n_exp) begin
            $display("Mismatch %s event count: expected %0d, actual %0d",
                     name, n_exp, ev_log.size());
            err_cnt++;
        end else begin
            for (int i = 0; i < n_exp; i++) begin
                e = exp[23-6*i -: 6];
                if (ev_log[i] != e) begin
                    $display("Mismatch %s event %0d: expected %h, actual %h",
                             name, i, e, ev_log[i]);
                    err_cnt++;
                end
            end
        end
    endtask

    // One byte, then either a full move or a quiet window
    task automatic run_byte(input string name, input logic [7:0] b, input logic stop_bit);
        logic [23:0] exp;
        logic        ok;
        ev_log.delete();
        busy_seen = 1'b0;
        exp = stop_bit ? expected_events(b) : '0;
        send_frame(b, stop_bit);
        if (exp != 0) begin
            wait_busy(1'b1, 200, ok);
            if (!ok) begin
                $display("%s: o_busy never rose after the command byte", name);
                err_cnt++;
            end else begin
                wait_busy(1'b0, move_cycles + frame, ok);
                if (!ok) begin
                    $display("%s: o_busy did not fall after the move", name);
                    err_cnt++;
                end
            end
        end else begin
            repeat (3 * frame) @(negedge sys_clk);
            if (busy_seen) begin
                $display("%s: o_busy rose for a byte that should be ignored", name);
                err_cnt++;
            end
        end
        compare_events(name, exp);
    endtask

    //////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////

    initial begin : main
        logic [7:0] b;
        logic       ok;
        seed = 47183;
        err_cnt = 0;
        cycle_cnt = 0;
        sys_clk = 1'b0;
        arst_n = 1'b0;
        rx_serial = 1'b1;
        busy_seen = 1'b0;
        for (int s = 0; s < 8; s++) begin
            hi_cnt[s] = 0;
            obs_code[s] = '0;
        end
        repeat (10) @(negedge sys_clk);
        arst_n = 1'b1;

        // All servos at rest once each has shown a full pulse
        for (int n = 0; n < 3 * frame && !all_observed(); n++) begin
            @(negedge sys_clk);
        end
        for (int s = 0; s < 8; s++) begin
            if (obs_code[s] != 3'd1) begin
                $display("Mismatch reset servo %0d: expected %0d, actual %0d",
                         s, 1, obs_code[s]);
                err_cnt++;
            end
        end
        if (busy !== 1'b0) begin
            $display("Mismatch reset busy: expected %b, actual %b", 1'b0, busy);
            err_cnt++;
        end

        run_byte("move_l", "L", 1'b1);
        run_byte("move_t", "T", 1'b1);
        run_byte("move_b", "B", 1'b1);
        run_byte("move_r", "R", 1'b1);

        for (int k = 0; k < 4; k++) begin
            b = 8'($random(seed));
            while (expected_events(b) != 0) begin
                b = 8'($random(seed));
            end
            run_byte("random_byte", b, 1'b1);
        end

        run_byte("bad_stop_l", "L", 1'b0);

        // Second command lands mid move and is lost
        ev_log.delete();
        send_frame("L", 1'b1);
        wait_busy(1'b1, 200, ok);
        if (!ok) begin
            $display("busy_drop: o_busy never rose after the first command");
            err_cnt++;
        end
        send_frame("T", 1'b1);
        wait_busy(1'b0, move_cycles + frame, ok);
        if (!ok) begin
            $display("busy_drop: o_busy did not fall after the first move");
            err_cnt++;
        end
        busy_seen = 1'b0;
        repeat (3 * frame) @(negedge sys_clk);
        if (busy_seen) begin
            $display("busy_drop: a command sent during a move was executed");
            err_cnt++;
        end
        compare_events("busy_drop", expected_events("L"));

        run_byte("back_to_back_b", "B", 1'b1);
        run_byte("back_to_back_t", "T", 1'b1);

        $display("Checks done with %0d errors", err_cnt);
        if (err_cnt == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: src.f
+incdir+include
logic/cube_pkg.sv
logic/uart_rx.sv
logic/move_decoder.sv
logic/move_sequencer.sv
logic/servo_pwm_bank.sv
logic/cube_solver_top.sv
sim/tb_cube_solver.sv
